/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_ym_top
FILELIST = build.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+design
design/ym_bus_pkg.sv
design/ym_timer_pkg.sv
design/ym_write_capture.sv
design/ym_write_fifo.sv
design/ym_reg_decoder.sv
design/ym_timers.sv
design/ym_top.sv
test/tb_ym_top.sv

/* design/ym_bus_pkg.sv */
// Host bus types shared by the write capture, write buffer and register decoder
package ym_bus_pkg;

    // Register number as written in an address cycle
    typedef logic [7:0] reg_addr_t;

    // Data byte on the host bus
    typedef logic [7:0] reg_data_t;

    // One queued host write
    typedef struct packed {
        logic      is_data; // High for a data write, low for an address write
        reg_data_t data;
    } bus_write_t;

    // Decoder FSM
    typedef enum logic [0:0] {
        DEC_IDLE = 1'b0,
        DEC_BUSY = 1'b1
    } dec_state_t;

endpackage

/* design/ym_defines.svh */
// Shared sizing, timing and register map constants for the FM chip host control path
`ifndef YM_DEFINES_SVH
`define YM_DEFINES_SVH

// Write buffer entries, also the credits the capture starts with
`define YM_FIFO_DEPTH 8

// Clocks the decoder holds busy after each data write
`define YM_BUSY_CYCLES 16

// Timer clocking
`define YM_TICK_DIV 4          // Clocks per timer A tick
`define YM_TIMER_B_PRESCALE 16 // Timer A ticks per timer B tick

// Register map
`define YM_REG_TIMER_A_HI 8'h24 // Timer A bits 9..2
`define YM_REG_TIMER_A_LO 8'h25 // Timer A bits 1..0
`define YM_REG_TIMER_B 8'h26
`define YM_REG_TIMER_CTRL 8'h27 // Run, IRQ enable and flag clear bits

`endif

/* design/ym_reg_decoder.sv */
// Register decoder that applies queued writes to the timer setup and forms the status byte
`include "ym_defines.svh"

module ym_reg_decoder
    import ym_bus_pkg::*;
    import ym_timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rec_valid,
    input  bus_write_t head_rec,
    output logic       pop,
    input  logic       write_lost,
    input  logic       flag_a,
    input  logic       flag_b,
    output timer_cfg_t timer_cfg,
    output reg_data_t  dout
);

    localparam int BUSY_W = $clog2(`YM_BUSY_CYCLES);
    typedef logic [BUSY_W-1:0] busy_cnt_t;

    dec_state_t state;
    busy_cnt_t  busy_cnt;
    reg_addr_t  cur_addr;   // Last address written
    logic       busy;

    // One entry at a time, only while idle
    assign pop  = rec_valid && (state == DEC_IDLE);
    assign busy = rec_valid || (state == DEC_BUSY);
    assign dout = {busy, write_lost, 4'b0000, flag_b, flag_a};

    // Busy period after each data write
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DEC_IDLE;
            busy_cnt <= '0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (pop && head_rec.is_data) begin
                        state    <= DEC_BUSY;
                        busy_cnt <= busy_cnt_t'(`YM_BUSY_CYCLES - 1);
                    end
                end
                DEC_BUSY: begin
                    if (busy_cnt == '0)
                        state <= DEC_IDLE;
                    else
                        busy_cnt <= busy_cnt - 1'b1;
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // Register writes
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_cfg <= '0;
            cur_addr  <= '0;
        end else begin
            timer_cfg.clr_a <= 1'b0;
            timer_cfg.clr_b <= 1'b0;
            if (pop && !head_rec.is_data) begin
                cur_addr <= head_rec.data;
            end else if (pop) begin
                case (cur_addr)
                    `YM_REG_TIMER_A_HI: timer_cfg.value_a[9:2] <= head_rec.data;
                    `YM_REG_TIMER_A_LO: timer_cfg.value_a[1:0] <= head_rec.data[1:0];
                    `YM_REG_TIMER_B:    timer_cfg.value_b      <= head_rec.data;
                    `YM_REG_TIMER_CTRL: begin
                        timer_cfg.run_a    <= head_rec.data[0];
                        timer_cfg.run_b    <= head_rec.data[1];
                        timer_cfg.irq_en_a <= head_rec.data[2];
                        timer_cfg.irq_en_b <= head_rec.data[3];
                        timer_cfg.clr_a    <= head_rec.data[4]; // Pulse, dropped next clock
                        timer_cfg.clr_b    <= head_rec.data[5];
                    end
                    default: ; // Unmapped registers are ignored
                endcase
            end
        end
    end

endmodule

/* design/ym_timer_pkg.sv */
// Timer value and configuration types shared by the register decoder and the timers
package ym_timer_pkg;

    typedef logic [9:0] timer_a_val_t;
    typedef logic [7:0] timer_b_val_t;

    // Timer setup as seen by the counters
    typedef struct packed {
        timer_a_val_t value_a;  // Reload value for timer A
        timer_b_val_t value_b;  // Reload value for timer B
        logic         run_a;
        logic         run_b;
        logic         irq_en_a;
        logic         irq_en_b;
        logic         clr_a;    // One cycle pulse
        logic         clr_b;    // One cycle pulse
    } timer_cfg_t;

endpackage

/* design/ym_timers.sv */
// Timer A and timer B counters with tick divider, overflow flags and active-low interrupt
`include "ym_defines.svh"

module ym_timers
    import ym_timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  timer_cfg_t timer_cfg,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    localparam int DIV_W = $clog2(`YM_TICK_DIV);
    localparam int PRE_W = $clog2(`YM_TIMER_B_PRESCALE);

    logic [DIV_W-1:0] div_cnt;
    logic [PRE_W-1:0] pre_cnt;
    logic             tick_a;
    logic             tick_b;
    timer_a_val_t     cnt_a;
    timer_b_val_t     cnt_b;
    logic             run_a_q;
    logic             run_b_q;
    logic             load_a;
    logic             load_b;

    assign tick_a = (div_cnt == DIV_W'(`YM_TICK_DIV - 1));
    assign tick_b = tick_a && (pre_cnt == PRE_W'(`YM_TIMER_B_PRESCALE - 1));

    // Load on the rising edge of run
    assign load_a = timer_cfg.run_a && !run_a_q;
    assign load_b = timer_cfg.run_b && !run_b_q;

    // Shared divider, free running
    always_ff @(posedge clk) begin
        if (rst)
            div_cnt <= '0;
        else
            div_cnt <= tick_a ? '0 : div_cnt + 1'b1;
    end

    // Timer B prescaler restarts on load so its period stays exact
    always_ff @(posedge clk) begin
        if (rst || load_b)
            pre_cnt <= '0;
        else if (tick_b)
            pre_cnt <= '0;
        else if (tick_a)
            pre_cnt <= pre_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_a_q <= 1'b0;
            run_b_q <= 1'b0;
            cnt_a   <= '0;
            cnt_b   <= '0;
            flag_a  <= 1'b0;
            flag_b  <= 1'b0;
        end else begin
            run_a_q <= timer_cfg.run_a;
            run_b_q <= timer_cfg.run_b;

            if (timer_cfg.clr_a)
                flag_a <= 1'b0;
            if (load_a) begin
                cnt_a <= timer_cfg.value_a;
            end else if (timer_cfg.run_a && tick_a) begin
                if (cnt_a == '1) begin
                    cnt_a  <= timer_cfg.value_a; // Reload on overflow
                    flag_a <= 1'b1;              // Wins over a clear in the same clock
                end else begin
                    cnt_a <= cnt_a + 1'b1;
                end
            end

            if (timer_cfg.clr_b)
                flag_b <= 1'b0;
            if (load_b) begin
                cnt_b <= timer_cfg.value_b;
            end else if (timer_cfg.run_b && tick_b) begin
                if (cnt_b == '1) begin
                    cnt_b  <= timer_cfg.value_b;
                    flag_b <= 1'b1;
                end else begin
                    cnt_b <= cnt_b + 1'b1;
                end
            end
        end
    end

    // Interrupt one clock behind the flags
    always_ff @(posedge clk) begin
        if (rst)
            irq_n <= 1'b1;
        else
            irq_n <= !((flag_a && timer_cfg.irq_en_a) || (flag_b && timer_cfg.irq_en_b));
    end

endmodule

/* design/ym_top.sv */
// FM chip host control path joining write capture, write buffer, decoder and timers
module ym_top
    import ym_bus_pkg::*;
    import ym_timer_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cs_n,
    input  logic      wr_n,
    input  logic      addr,
    input  reg_data_t din,
    output reg_data_t dout,
    output logic      irq_n
);

    logic       push;
    bus_write_t push_rec;
    logic       credit_ret;
    logic       write_lost;
    logic       rec_valid;
    bus_write_t head_rec;
    logic       pop;
    timer_cfg_t timer_cfg;
    logic       flag_a;
    logic       flag_b;

    ym_write_capture capture_i (
        .clk        (clk),
        .rst        (rst),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .addr       (addr),
        .din        (din),
        .credit_ret (credit_ret),
        .push       (push),
        .push_rec   (push_rec),
        .write_lost (write_lost)
    );

    ym_write_fifo fifo_i (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_rec   (push_rec),
        .pop        (pop),
        .rec_valid  (rec_valid),
        .head_rec   (head_rec),
        .credit_ret (credit_ret)
    );

    ym_reg_decoder decoder_i (
        .clk        (clk),
        .rst        (rst),
        .rec_valid  (rec_valid),
        .head_rec   (head_rec),
        .pop        (pop),
        .write_lost (write_lost),
        .flag_a     (flag_a),
        .flag_b     (flag_b),
        .timer_cfg  (timer_cfg),
        .dout       (dout)
    );

    ym_timers timers_i (
        .clk       (clk),
        .rst       (rst),
        .timer_cfg (timer_cfg),
        .flag_a    (flag_a),
        .flag_b    (flag_b),
        .irq_n     (irq_n)
    );

endmodule

/* design/ym_write_capture.sv */
// Host write capture that queues each bus write under credit control and flags lost writes
`include "ym_defines.svh"

module ym_write_capture
    import ym_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic       addr,
    input  reg_data_t  din,
    input  logic       credit_ret,
    output logic       push,
    output bus_write_t push_rec,
    output logic       write_lost
);

    localparam int CREDIT_W = $clog2(`YM_FIFO_DEPTH + 1);
    typedef logic [CREDIT_W-1:0] credit_t;

    credit_t credits;
    logic    host_wr;
    logic    spend;

    assign host_wr = !cs_n && !wr_n;
    assign spend   = host_wr && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits    <= credit_t'(`YM_FIFO_DEPTH);
            push       <= 1'b0;
            write_lost <= 1'b0;
        end else begin
            push <= spend;
            if (host_wr && credits == '0)
                write_lost <= 1'b1; // Sticky until reset
            case ({spend, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;    // Both or neither
            endcase
        end
    end

    // Record follows the write by one clock, same as push
    always_ff @(posedge clk) begin
        push_rec.is_data <= addr;
        push_rec.data    <= din;
    end

endmodule

/* design/ym_write_fifo.sv */
// In-order write buffer between capture and decoder, returning one credit per pop
`include "ym_defines.svh"

module ym_write_fifo
    import ym_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  bus_write_t push_rec,
    input  logic       pop,
    output logic       rec_valid,
    output bus_write_t head_rec,
    output logic       credit_ret
);

    localparam int PTR_W = $clog2(`YM_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`YM_FIFO_DEPTH + 1);
    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    bus_write_t mem [`YM_FIFO_DEPTH];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;

    assign rec_valid = (count != '0);
    assign head_rec  = mem[rd_ptr];   // Oldest entry

    // Storage
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_rec;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop;
            if (push)
                wr_ptr <= (wr_ptr == ptr_t'(`YM_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ptr_t'(`YM_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Credits upstream keep push from overrunning a full queue
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* test/tb_ym_top.sv */
// Testbench for the FM chip host control path covering busy, timers, flag clear and write loss
`include "ym_defines.svh"

module tb_ym_top
    import ym_bus_pkg::*;
    import ym_timer_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Longest timer periods for the random ranges used below
    localparam int MAX_PERIOD_A = (1024 - 1000) * `YM_TICK_DIV;
    localparam int MAX_PERIOD_B = (256 - 250) * `YM_TICK_DIV * `YM_TIMER_B_PRESCALE;
    localparam int WRITE_TIME   = 12 * (`YM_BUSY_CYCLES + 4) + 4 * `YM_FIFO_DEPTH;
    localparam int CYCLE_LIMIT  = 2 * (MAX_PERIOD_A + MAX_PERIOD_B + WRITE_TIME);

    logic        clk;
    logic        rst;
    logic        cs_n;
    logic        wr_n;
    logic        addr;
    reg_data_t   din;
    reg_data_t   dout;
    logic        irq_n;

    int          cycle_count;
    int          test_errs;
    int          pass_count;
    int          fail_count;
    logic [31:0] rng;

    ym_top dut_i (
        .clk   (clk),
        .rst   (rst),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .addr  (addr),
        .din   (din),
        .dout  (dout),
        .irq_n (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d clocks", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected status byte from its bit map
    function automatic reg_data_t status_byte(input logic busy, input logic lost,
                                              input logic fb, input logic fa);
        return {busy, lost, 4'b0000, fb, fa};
    endfunction

    function automatic int period_a(input timer_a_val_t v);
        return (1024 - int'(v)) * `YM_TICK_DIV;
    endfunction

    function automatic int period_b(input timer_b_val_t v);
        return (256 - int'(v)) * `YM_TICK_DIV * `YM_TIMER_B_PRESCALE;
    endfunction

    // Drive and sample point, 10 ns past the rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic host_write(input logic a, input reg_data_t d);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = a;
        din  = d;
        step();
        cs_n = 1'b1;   // Back-to-back calls keep the strobe low
        wr_n = 1'b1;
    endtask

    task automatic polite_write(input logic a, input reg_data_t d);
        while (dout[7])
            step();
        host_write(a, d);
    endtask

    task automatic write_reg(input reg_addr_t r, input reg_data_t d);
        polite_write(1'b0, r);
        polite_write(1'b1, d);
    endtask

    // Waits for a status bit, noting any irq_n low on the way
    task automatic wait_status_bit(input int idx, input int limit, output int waited,
                                   output logic irq_low);
        waited  = 0;
        irq_low = 1'b0;
        while (!dout[idx] && waited <= limit) begin
            step();
            waited++;
            if (!irq_n)
                irq_low = 1'b1;
        end
    endtask

    task automatic report_mismatch(input string name, input reg_data_t expected,
                                   input reg_data_t actual);
        $display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
        test_errs++;
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        test_errs++;
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("PASS %s", name);
            pass_count++;
        end else begin
            $display("FAIL %s", name);
            fail_count++;
        end
        test_errs = 0;
    endtask

    initial begin
        timer_a_val_t va;
        timer_b_val_t vb;
        int           exp_cycles;
        int           waited;
        logic         irq_low;

        rst        = 1'b1;
        cs_n       = 1'b1;
        wr_n       = 1'b1;
        addr       = 1'b0;
        din        = '0;
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;
        rng        = 32'd1;
        repeat (2) step();
        rst = 1'b0;

        step();
        if (dout !== status_byte(1'b0, 1'b0, 1'b0, 1'b0))
            report_mismatch("reset status", status_byte(1'b0, 1'b0, 1'b0, 1'b0), dout);
        if (irq_n !== 1'b1)
            report_mismatch("reset irq_n", 8'h01, 8'(irq_n));
        end_test("reset");

        write_reg(8'h20, 8'h55);   // Unmapped register, busy only
        waited = 0;
        while (!dout[7] && waited < 4) begin
            step();
            waited++;
        end
        if (!dout[7])
            report_error("busy did not rise after a data write");
        waited = 0;
        while (dout[7] && waited < `YM_BUSY_CYCLES + 4) begin
            step();
            waited++;
        end
        if (dout[7])
            report_error("busy still high after the busy period");
        if (dout !== status_byte(1'b0, 1'b0, 1'b0, 1'b0))
            report_mismatch("busy status", status_byte(1'b0, 1'b0, 1'b0, 1'b0), dout);
        end_test("busy");

        // Period of at least 36 clocks leaves room for the clear write
        rng = xorshift32(rng);
        va  = timer_a_val_t'(1000 + rng % 16);
        write_reg(`YM_REG_TIMER_A_HI, va[9:2]);
        write_reg(`YM_REG_TIMER_A_LO, {6'b000000, va[1:0]});
        write_reg(`YM_REG_TIMER_CTRL, 8'h05);   // run_a and irq_en_a
        exp_cycles = period_a(va);
        wait_status_bit(0, exp_cycles + 8, waited, irq_low);
        if (!dout[0] || waited > exp_cycles + 8)
            report_error($sformatf("timer A flag did not rise within %0d clocks",
                                   exp_cycles + 8));
        else if (waited < exp_cycles - 8)
            report_error($sformatf("timer A flag rose after %0d clocks, expected about %0d",
                                   waited, exp_cycles));
        else if (dout !== status_byte(1'b0, 1'b0, 1'b0, 1'b1))
            report_mismatch("timer A status", status_byte(1'b0, 1'b0, 1'b0, 1'b1), dout);
        step();
        if (irq_n !== 1'b0)
            report_mismatch("timer A irq_n", 8'h00, 8'(irq_n));
        end_test("timer A");

        write_reg(`YM_REG_TIMER_CTRL, 8'h15);   // Clear A, keep run_a and irq_en_a
        waited = 0;
        while (dout[0] && waited < 8) begin
            step();
            waited++;
        end
        if (dout[0] !== 1'b0)
            report_mismatch("clear status bit 0", 8'h00, 8'(dout[0]));
        step();
        if (irq_n !== 1'b1)
            report_mismatch("clear irq_n", 8'h01, 8'(irq_n));
        end_test("timer clear");

        write_reg(`YM_REG_TIMER_CTRL, 8'h01);   // Timer A interrupt off before timer B runs
        rng = xorshift32(rng);
        vb  = timer_b_val_t'(250 + rng % 6);
        write_reg(`YM_REG_TIMER_B, vb);
        write_reg(`YM_REG_TIMER_CTRL, 8'h02);   // run_b alone, no interrupts
        exp_cycles = period_b(vb);
        wait_status_bit(1, exp_cycles + 8, waited, irq_low);
        if (!dout[1] || waited > exp_cycles + 8)
            report_error($sformatf("timer B flag did not rise within %0d clocks",
                                   exp_cycles + 8));
        else if (waited < exp_cycles - 8)
            report_error($sformatf("timer B flag rose after %0d clocks, expected about %0d",
                                   waited, exp_cycles));
        step();   // irq_n lags the flag by one clock
        if (irq_low || irq_n !== 1'b1)
            report_error("irq_n went low while both interrupt enables were off");
        end_test("timer B");

        polite_write(1'b0, 8'h20);   // Burst data lands in an unmapped register
        step();
        while (dout[7])
            step();
        repeat (`YM_FIFO_DEPTH) host_write(1'b1, 8'hA5);
        step();
        if (dout[6] !== 1'b0)
            report_mismatch("write loss first burst", 8'h00, 8'(dout[6]));
        repeat (3 * `YM_FIFO_DEPTH) host_write(1'b1, 8'h5A);
        step();
        if (dout[6] !== 1'b1)
            report_mismatch("write loss second burst", 8'h01, 8'(dout[6]));
        end_test("write loss");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
